// File: sim.f
logic/bpred_pkg.sv
logic/branch_predictor.sv
logic/fetch_pc_gen.sv
logic/branch_resolve.sv
logic/fetch_predict_top.sv
bench/fetch_predict_props.sv
bench/fetch_predict_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, pass or fail from the log

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module fetch_predict_tb \
    -f sim.f -o fetch_predict_sim > build.log 2>&1 \
    && ./obj_dir/fetch_predict_sim > sim.log 2>&1

grep -q "Simulation PASSED" sim.log && echo "Run passed" || {
    echo "Run failed, see build.log and sim.log"
    exit 1
}

// File: bench/fetch_predict_tb.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_predict_tb;

    localparam int CLK_PERIOD = 20;
    localparam int RESET_CYCLES = 4;
    localparam int MAX_ROWS = 160;
    localparam int NUM_TESTS = 6;

    logic clk;
    logic reset;
    logic fetch_enable;
    logic resolve_valid;
    bpred_pkg::addr_t resolve_pc;
    logic resolve_taken;
    bpred_pkg::addr_t resolve_target;
    logic resolve_pred_taken;
    bpred_pkg::addr_t resolve_pred_target;

    bpred_pkg::addr_t fetch_pc;
    logic pred_hit;
    logic pred_taken;
    bpred_pkg::addr_t pred_target;
    logic redirect;
    bpred_pkg::count_t branch_count;
    bpred_pkg::count_t mispredict_count;

    // Stimulus columns
    int row_test [MAX_ROWS];
    logic row_fe [MAX_ROWS];
    logic row_rv [MAX_ROWS];
    bpred_pkg::addr_t row_pc [MAX_ROWS];
    logic row_taken [MAX_ROWS];
    bpred_pkg::addr_t row_target [MAX_ROWS];
    logic row_ptaken [MAX_ROWS];
    bpred_pkg::addr_t row_ptarget [MAX_ROWS];
    logic row_auto [MAX_ROWS];

    // Expected columns filled by the model
    bpred_pkg::addr_t exp_pc [MAX_ROWS];
    logic exp_hit [MAX_ROWS];
    logic exp_taken [MAX_ROWS];
    bpred_pkg::addr_t exp_target [MAX_ROWS];
    logic exp_redirect [MAX_ROWS];
    bpred_pkg::count_t exp_branches [MAX_ROWS];
    bpred_pkg::count_t exp_misses [MAX_ROWS];
    int row_count = 0;

    // Reference model state
    bpred_pkg::addr_t m_pc;
    logic m_valid [bpred_pkg::TABLE_DEPTH];
    bpred_pkg::word_addr_t m_tag [bpred_pkg::TABLE_DEPTH];
    bpred_pkg::word_addr_t m_target [bpred_pkg::TABLE_DEPTH];
    bpred_pkg::ctr_t m_ctr [bpred_pkg::TABLE_DEPTH];
    logic m_train_en;
    bpred_pkg::addr_t m_train_pc;
    logic m_train_taken;
    bpred_pkg::addr_t m_train_target;
    logic m_redirect;
    bpred_pkg::addr_t m_redirect_pc;
    bpred_pkg::count_t m_branches;
    bpred_pkg::count_t m_misses;

    logic [15:0] lfsr_state = 16'd26579;
    int errors = 0;
    int test_errors [NUM_TESTS+1];
    string test_name [NUM_TESTS+1];
    logic built = 1'b0;

    fetch_predict_top uut (
        .clk                 (clk),
        .reset               (reset),
        .fetch_enable        (fetch_enable),
        .resolve_valid       (resolve_valid),
        .resolve_pc          (resolve_pc),
        .resolve_taken       (resolve_taken),
        .resolve_target      (resolve_target),
        .resolve_pred_taken  (resolve_pred_taken),
        .resolve_pred_target (resolve_pred_target),
        .fetch_pc            (fetch_pc),
        .pred_hit            (pred_hit),
        .pred_taken          (pred_taken),
        .pred_target         (pred_target),
        .redirect            (redirect),
        .branch_count        (branch_count),
        .mispredict_count    (mispredict_count)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic int slot_of(input bpred_pkg::addr_t a);
        return int'(a[5:2]);
    endfunction

    task automatic add_row(input int test, input logic fe, input logic rv,
                           input bpred_pkg::addr_t pc, input logic taken,
                           input bpred_pkg::addr_t target, input logic ptaken,
                           input bpred_pkg::addr_t ptarget, input logic auto_pred);
        row_test[row_count] = test;
        row_fe[row_count] = fe;
        row_rv[row_count] = rv;
        row_pc[row_count] = pc;
        row_taken[row_count] = taken;
        row_target[row_count] = target;
        row_ptaken[row_count] = ptaken;
        row_ptarget[row_count] = ptarget;
        row_auto[row_count] = auto_pred;
        row_count++;
    endtask

    task automatic add_idle(input int test, input logic fe, input int n);
        for (int k = 0; k < n; k++) begin
            add_row(test, fe, 1'b0, '0, 1'b0, '0, 1'b0, '0, 1'b0);
        end
    endtask

    // Cold taken branch elsewhere lands fetch on dest
    task automatic steer_fetch(input int test, input bpred_pkg::addr_t from,
                               input bpred_pkg::addr_t dest);
        add_row(test, 1'b0, 1'b1, from, 1'b1, dest, 1'b0, '0, 1'b0);
        add_idle(test, 1'b0, 2);
    endtask

    task automatic build_table();
        logic outcomes [6];
        logic dir;
        outcomes = '{1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0};
        add_idle(1, 1'b1, 4);
        add_idle(1, 1'b0, 2);
        add_idle(1, 1'b1, 1);
        add_idle(1, 1'b0, 1);
        add_row(2, 1'b0, 1'b1, 32'h100, 1'b1, 32'h200, 1'b0, '0, 1'b0);
        add_idle(2, 1'b0, 3);
        add_row(3, 1'b0, 1'b1, 32'h100, 1'b1, 32'h200, 1'b1, 32'h200, 1'b0);
        add_idle(3, 1'b0, 1);
        steer_fetch(3, 32'h3c4, 32'h100);
        add_idle(3, 1'b1, 1);
        add_idle(3, 1'b0, 2);
        steer_fetch(4, 32'h3cc, 32'h148);
        for (int k = 0; k < 6; k++) begin
            add_row(4, 1'b0, 1'b1, 32'h148, outcomes[k], 32'h400, outcomes[k],
                    outcomes[k] ? 32'h400 : 32'h0, 1'b0);
            add_idle(4, 1'b0, 2);
        end
        add_row(5, 1'b0, 1'b1, 32'h500, 1'b1, 32'h580, 1'b1, 32'h580, 1'b0);
        add_idle(5, 1'b0, 1);
        steer_fetch(5, 32'h3d0, 32'h500);
        add_row(5, 1'b0, 1'b1, 32'h540, 1'b1, 32'h5c0, 1'b1, 32'h5c0, 1'b0);
        add_idle(5, 1'b0, 2);
        for (int k = 0; k < 10; k++) begin
            lfsr_state = lfsr_step(lfsr_state);
            dir = lfsr_state[0];
            add_row(5, 1'b0, 1'b1, 32'h600, dir, 32'h700, 1'b0, '0, 1'b1);
            add_idle(5, 1'b0, 1);
        end
        add_idle(5, 1'b0, 1);
        add_row(6, 1'b0, 1'b1, 32'h24c, 1'b1, 32'h800, 1'b0, '0, 1'b0);
        add_idle(6, 1'b0, 2);
        add_row(6, 1'b0, 1'b1, 32'h2f0, 1'b0, 32'h900, 1'b0, '0, 1'b0);
        add_idle(6, 1'b0, 3);
    endtask

    task automatic run_model();
        int idx;
        int ridx;
        logic hit;
        logic tk;
        logic mis;
        bpred_pkg::addr_t next_pc;
        m_pc = bpred_pkg::RESET_PC;
        for (int s = 0; s < bpred_pkg::TABLE_DEPTH; s++) begin
            m_valid[s] = 1'b0;
            m_ctr[s] = 2'b01;
            m_tag[s] = '0;
            m_target[s] = '0;
        end
        m_train_en = 1'b0;
        m_redirect = 1'b0;
        m_branches = '0;
        m_misses = '0;
        for (int i = 0; i < row_count; i++) begin
            idx = slot_of(m_pc);
            hit = m_valid[idx] && (m_tag[idx] == m_pc[31:2]);
            tk = m_ctr[idx] >= 2'b10;
            exp_pc[i] = m_pc;
            exp_hit[i] = hit;
            exp_taken[i] = tk;
            exp_target[i] = {m_target[idx], 2'b00};
            exp_redirect[i] = m_redirect;
            exp_branches[i] = m_branches;
            exp_misses[i] = m_misses;
            if (row_auto[i]) begin
                ridx = slot_of(row_pc[i]);
                row_ptaken[i] = m_valid[ridx] && (m_tag[ridx] == row_pc[i][31:2])
                                && (m_ctr[ridx] >= 2'b10);
                row_ptarget[i] = row_ptaken[i] ? {m_target[ridx], 2'b00} : 32'h0;
            end
            if (m_redirect) begin
                next_pc = m_redirect_pc;
            end else if (row_fe[i]) begin
                next_pc = (hit && tk) ? {m_target[idx], 2'b00} : m_pc + 32'd4;
            end else begin
                next_pc = m_pc;
            end
            m_pc = next_pc;
            if (m_train_en) begin
                ridx = slot_of(m_train_pc);
                m_tag[ridx] = m_train_pc[31:2];
                m_target[ridx] = m_train_target[31:2];
                m_valid[ridx] = 1'b1;
                if (m_train_taken && m_ctr[ridx] != 2'b11) begin
                    m_ctr[ridx] = m_ctr[ridx] + 2'd1;
                end else if (!m_train_taken && m_ctr[ridx] != 2'b00) begin
                    m_ctr[ridx] = m_ctr[ridx] - 2'd1;
                end
            end
            mis = (row_taken[i] != row_ptaken[i])
                  || (row_taken[i] && row_ptaken[i] && row_target[i] != row_ptarget[i]);
            m_train_en = row_rv[i];
            m_redirect = row_rv[i] && mis;
            if (row_rv[i]) begin
                m_train_pc = row_pc[i];
                m_train_taken = row_taken[i];
                m_train_target = row_target[i];
                m_redirect_pc = row_taken[i] ? row_target[i] : row_pc[i] + 32'd4;
                m_branches = m_branches + 16'd1;
                if (mis) begin
                    m_misses = m_misses + 16'd1;
                end
            end
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual, input int test);
        assert (actual === expected) else begin
            $display("Mismatch at %0t: %s expected %h got %h", $time, name, expected, actual);
            errors++;
            test_errors[test]++;
        end
    endtask

    initial begin
        reset = 1'b1;
        fetch_enable = 1'b0;
        resolve_valid = 1'b0;
        resolve_pc = '0;
        resolve_taken = 1'b0;
        resolve_target = '0;
        resolve_pred_taken = 1'b0;
        resolve_pred_target = '0;
        test_name = '{"", "reset and sequential fetch", "cold mispredict",
                      "predicted fetch", "counter hysteresis", "aliasing and random",
                      "redirect under hold"};
        for (int t = 0; t <= NUM_TESTS; t++) begin
            test_errors[t] = 0;
        end
        build_table();
        run_model();
        built = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        for (int i = 0; i < row_count; i++) begin
            @(posedge clk);
            fetch_enable <= row_fe[i];
            resolve_valid <= row_rv[i];
            resolve_pc <= row_pc[i];
            resolve_taken <= row_taken[i];
            resolve_target <= row_target[i];
            resolve_pred_taken <= row_ptaken[i];
            resolve_pred_target <= row_ptarget[i];
            @(negedge clk);
            check_value("fetch_pc", exp_pc[i], fetch_pc, row_test[i]);
            check_value("pred_hit", 32'(exp_hit[i]), 32'(pred_hit), row_test[i]);
            if (exp_hit[i]) begin
                check_value("pred_taken", 32'(exp_taken[i]), 32'(pred_taken), row_test[i]);
                check_value("pred_target", exp_target[i], pred_target, row_test[i]);
            end
            check_value("redirect", 32'(exp_redirect[i]), 32'(redirect), row_test[i]);
            check_value("branch_count", 32'(exp_branches[i]), 32'(branch_count), row_test[i]);
            check_value("mispredict_count", 32'(exp_misses[i]), 32'(mispredict_count),
                        row_test[i]);
            if (i == row_count - 1 || row_test[i+1] != row_test[i]) begin
                $display("Test %0d %s: %s (%0d errors)", row_test[i], test_name[row_test[i]],
                         test_errors[row_test[i]] == 0 ? "ok" : "errors",
                         test_errors[row_test[i]]);
            end
        end
        $display("Rows applied: %0d, errors: %0d", row_count, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        wait (built);
        #((row_count + RESET_CYCLES + 20) * CLK_PERIOD);
        $display("Watchdog timeout: the stimulus table did not finish in time");
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: bench/fetch_predict_props.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_predict_props (
    input wire                      clk,
    input wire                      reset,
    input wire                      resolve_valid,
    input wire                      redirect,
    input wire bpred_pkg::count_t   branch_count,
    input wire bpred_pkg::count_t   mispredict_count
);

    // Redirect only after a sampled resolve
    redirect_after_resolve: assert property (@(posedge clk) disable iff (reset)
        redirect |-> $past(resolve_valid))
        else $error("redirect without a resolve in the previous cycle");

    redirect_single_pulse: assert property (@(posedge clk) disable iff (reset)
        redirect && !resolve_valid |=> !redirect)
        else $error("redirect held longer than one cycle");

    branch_count_steps: assert property (@(posedge clk) disable iff (reset)
        (branch_count == $past(branch_count))
        || (branch_count == bpred_pkg::count_t'($past(branch_count) + 16'd1)))
        else $error("branch_count moved other than by one");

    mispredict_count_steps: assert property (@(posedge clk) disable iff (reset)
        (mispredict_count == $past(mispredict_count))
        || (mispredict_count == bpred_pkg::count_t'($past(mispredict_count) + 16'd1)))
        else $error("mispredict_count moved other than by one");

    redirect_low_after_reset: assert property (@(posedge clk)
        !reset && $past(reset) |-> !redirect)
        else $error("redirect high right after reset");

endmodule

bind fetch_predict_top fetch_predict_props u_props (
    .clk              (clk),
    .reset            (reset),
    .resolve_valid    (resolve_valid),
    .redirect         (redirect),
    .branch_count     (branch_count),
    .mispredict_count (mispredict_count)
);

`default_nettype wire

// File: logic/fetch_predict_top.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_predict_top (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     fetch_enable,

    input  wire                     resolve_valid,
    input  wire bpred_pkg::addr_t   resolve_pc,
    input  wire                     resolve_taken,
    input  wire bpred_pkg::addr_t   resolve_target,
    input  wire                     resolve_pred_taken,
    input  wire bpred_pkg::addr_t   resolve_pred_target,

    output bpred_pkg::addr_t        fetch_pc,
    output logic                    pred_hit,
    output logic                    pred_taken,
    output bpred_pkg::addr_t        pred_target,
    output logic                    redirect,
    output bpred_pkg::count_t       branch_count,
    output bpred_pkg::count_t       mispredict_count
);

    logic train_enable;
    bpred_pkg::addr_t train_pc;
    logic train_taken;
    bpred_pkg::addr_t train_target;
    bpred_pkg::addr_t redirect_pc;

    branch_predictor u_predictor (
        .clk          (clk),
        .reset        (reset),
        .fetch_pc     (fetch_pc),
        .pred_hit     (pred_hit),
        .pred_taken   (pred_taken),
        .pred_target  (pred_target),
        .train_enable (train_enable),
        .train_pc     (train_pc),
        .train_taken  (train_taken),
        .train_target (train_target)
    );

    fetch_pc_gen u_pc_gen (
        .clk          (clk),
        .reset        (reset),
        .fetch_enable (fetch_enable),
        .pred_hit     (pred_hit),
        .pred_taken   (pred_taken),
        .pred_target  (pred_target),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .fetch_pc     (fetch_pc)
    );

    branch_resolve u_resolve (
        .clk                 (clk),
        .reset               (reset),
        .resolve_valid       (resolve_valid),
        .resolve_pc          (resolve_pc),
        .resolve_taken       (resolve_taken),
        .resolve_target      (resolve_target),
        .resolve_pred_taken  (resolve_pred_taken),
        .resolve_pred_target (resolve_pred_target),
        .train_enable        (train_enable),
        .train_pc            (train_pc),
        .train_taken         (train_taken),
        .train_target        (train_target),
        .redirect            (redirect),
        .redirect_pc         (redirect_pc),
        .branch_count        (branch_count),
        .mispredict_count    (mispredict_count)
    );

endmodule

`default_nettype wire

// File: logic/branch_resolve.sv
`timescale 1ns/10ps
`default_nettype none

module branch_resolve (
    input  wire                     clk,
    input  wire                     reset,

    // Resolved branch from execute
    input  wire                     resolve_valid,
    input  wire bpred_pkg::addr_t   resolve_pc,
    input  wire                     resolve_taken,
    input  wire bpred_pkg::addr_t   resolve_target,

    // Prediction carried along with the branch
    input  wire                     resolve_pred_taken,
    input  wire bpred_pkg::addr_t   resolve_pred_target,

    // Training toward the predictor
    output logic                    train_enable,
    output bpred_pkg::addr_t        train_pc,
    output logic                    train_taken,
    output bpred_pkg::addr_t        train_target,

    // Fetch correction
    output logic                    redirect,
    output bpred_pkg::addr_t        redirect_pc,

    output bpred_pkg::count_t       branch_count,
    output bpred_pkg::count_t       mispredict_count
);

    logic dir_wrong;
    logic target_wrong;
    logic mispredict;
    bpred_pkg::addr_t fall_through;
    bpred_pkg::addr_t correct_pc;

    assign dir_wrong = resolve_taken != resolve_pred_taken;
    // Same direction but a stale predicted target
    assign target_wrong = resolve_taken && resolve_pred_taken
                          && (resolve_target != resolve_pred_target);
    assign mispredict = dir_wrong || target_wrong;

    assign fall_through = resolve_pc + bpred_pkg::INSTR_BYTES;
    assign correct_pc = resolve_taken ? resolve_target : fall_through;

    // Strobes and statistics
    always_ff @(posedge clk) begin
        if (reset) begin
            train_enable <= 1'b0;
            redirect <= 1'b0;
            branch_count <= '0;
            mispredict_count <= '0;
        end else begin
            train_enable <= resolve_valid;
            redirect <= resolve_valid && mispredict;
            if (resolve_valid) begin
                branch_count <= branch_count + bpred_pkg::count_t'(1);
            end
            if (resolve_valid && mispredict) begin
                mispredict_count <= mispredict_count + bpred_pkg::count_t'(1);
            end
        end
    end

    // Branch payload toward training and fetch
    always_ff @(posedge clk) begin
        if (resolve_valid) begin
            train_pc <= resolve_pc;
            train_taken <= resolve_taken;
            train_target <= resolve_target;
            redirect_pc <= correct_pc;
        end
    end

endmodule

`default_nettype wire

// File: logic/fetch_pc_gen.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_pc_gen (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     fetch_enable,

    // Prediction for the current fetch address
    input  wire                     pred_hit,
    input  wire                     pred_taken,
    input  wire bpred_pkg::addr_t   pred_target,

    // Correction from the resolution unit
    input  wire                     redirect,
    input  wire bpred_pkg::addr_t   redirect_pc,

    output bpred_pkg::addr_t        fetch_pc
);

    bpred_pkg::addr_t seq_pc;
    bpred_pkg::addr_t next_pc;
    logic follow_pred;

    assign seq_pc = fetch_pc + bpred_pkg::INSTR_BYTES;
    assign follow_pred = pred_hit && pred_taken;

    // Redirect wins, even while fetch is held
    always_comb begin
        next_pc = fetch_pc;
        if (redirect) begin
            next_pc = redirect_pc;
        end else if (fetch_enable) begin
            if (follow_pred) begin
                next_pc = pred_target;
            end else begin
                next_pc = seq_pc;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_pc <= bpred_pkg::RESET_PC;
        end else begin
            fetch_pc <= next_pc;
        end
    end

endmodule

`default_nettype wire

// File: logic/branch_predictor.sv
`timescale 1ns/10ps
`default_nettype none

module branch_predictor (
    input  wire                     clk,
    input  wire                     reset,

    // Lookup side
    input  wire bpred_pkg::addr_t   fetch_pc,
    output logic                    pred_hit,
    output logic                    pred_taken,
    output bpred_pkg::addr_t        pred_target,

    // Training from the resolution unit
    input  wire                     train_enable,
    input  wire bpred_pkg::addr_t   train_pc,
    input  wire                     train_taken,
    input  wire bpred_pkg::addr_t   train_target
);

    // Table storage, one slot per index
    bpred_pkg::word_addr_t tag_mem [bpred_pkg::TABLE_DEPTH];
    bpred_pkg::word_addr_t target_mem [bpred_pkg::TABLE_DEPTH];
    bpred_pkg::ctr_t ctr_mem [bpred_pkg::TABLE_DEPTH];
    logic [bpred_pkg::TABLE_DEPTH-1:0] valid;

    bpred_pkg::index_t lookup_index;
    bpred_pkg::word_addr_t lookup_word;
    bpred_pkg::ctr_t lookup_ctr;

    bpred_pkg::index_t train_index;
    bpred_pkg::word_addr_t train_word;
    bpred_pkg::ctr_t train_ctr;
    bpred_pkg::ctr_t train_ctr_next;

    // One step toward the actual direction, held at both ends
    function automatic bpred_pkg::ctr_t ctr_step(
        input bpred_pkg::ctr_t ctr,
        input logic taken
    );
        bpred_pkg::ctr_t result;
        result = ctr;
        if (taken) begin
            if (ctr != bpred_pkg::CTR_STRONG_TAKEN) begin
                result = ctr + 2'd1;
            end
        end else begin
            if (ctr != bpred_pkg::CTR_STRONG_NT) begin
                result = ctr - 2'd1;
            end
        end
        return result;
    endfunction

    // Lookup path
    assign lookup_index = bpred_pkg::index_of(fetch_pc);
    assign lookup_word = bpred_pkg::word_of(fetch_pc);
    assign lookup_ctr = ctr_mem[lookup_index];

    // Full word address kept as tag, so index bits compare too
    assign pred_hit = valid[lookup_index] && (tag_mem[lookup_index] == lookup_word);
    assign pred_taken = lookup_ctr >= bpred_pkg::CTR_WEAK_TAKEN;
    assign pred_target = bpred_pkg::byte_of(target_mem[lookup_index]);

    // Training path
    assign train_index = bpred_pkg::index_of(train_pc);
    assign train_word = bpred_pkg::word_of(train_pc);
    assign train_ctr = ctr_mem[train_index];
    assign train_ctr_next = ctr_step(train_ctr, train_taken);

    always_ff @(posedge clk) begin
        if (train_enable) begin
            tag_mem[train_index] <= train_word;
            target_mem[train_index] <= bpred_pkg::word_of(train_target);
        end
    end

    // A new branch in a slot inherits the old counter
    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= '0;
            for (int i = 0; i < bpred_pkg::TABLE_DEPTH; i++) begin
                ctr_mem[i] <= bpred_pkg::CTR_INIT;
            end
        end else if (train_enable) begin
            valid[train_index] <= 1'b1;
            ctr_mem[train_index] <= train_ctr_next;
        end
    end

endmodule

`default_nettype wire

// File: logic/bpred_pkg.sv
`default_nettype none

package bpred_pkg;

    localparam int ADDR_BITS = 32;
    localparam int WORD_ADDR_BITS = ADDR_BITS - 2;
    localparam int INDEX_BITS = 4;
    localparam int TABLE_DEPTH = 2 ** INDEX_BITS;
    localparam int COUNT_BITS = 16;

    typedef logic [ADDR_BITS-1:0] addr_t;
    typedef logic [WORD_ADDR_BITS-1:0] word_addr_t;
    typedef logic [INDEX_BITS-1:0] index_t;
    typedef logic [1:0] ctr_t;
    typedef logic [COUNT_BITS-1:0] count_t;

    // 2-bit counter states, taken from weak taken upward
    localparam ctr_t CTR_STRONG_NT = 2'b00;
    localparam ctr_t CTR_WEAK_NT = 2'b01;
    localparam ctr_t CTR_WEAK_TAKEN = 2'b10;
    localparam ctr_t CTR_STRONG_TAKEN = 2'b11;
    localparam ctr_t CTR_INIT = CTR_WEAK_NT;

    localparam addr_t RESET_PC = '0;
    localparam addr_t INSTR_BYTES = 32'd4;

    function automatic word_addr_t word_of(input addr_t addr);
        return addr[ADDR_BITS-1:2];
    endfunction

    function automatic index_t index_of(input addr_t addr);
        return addr[INDEX_BITS+1:2];
    endfunction

    function automatic addr_t byte_of(input word_addr_t word);
        return {word, 2'b00};
    endfunction

endpackage

`default_nettype wire
